// ==== rtl/alu_pkg.sv ====
// vector alu package: lane count, data widths, opcodes, source codes and the instruction word
`default_nettype none

package alu_pkg;

	// ==================================================
	// widths
	// ==================================================

	// lane count of every vector
	localparam int LANES = 4;

	// working lane value inside the alu
	typedef logic signed [15:0] elem_t;
	// sram reads a stream lane as signed and dram takes it raw
	typedef logic [7:0] data_t;

	typedef elem_t [LANES-1:0] elem_vec_t;
	typedef data_t [LANES-1:0] data_vec_t;

	typedef logic [3:0] reg_addr_t;
	// shift amount or the sub-code of the logic group
	typedef logic [4:0] shamt_t;

	// to_dram code that disables the dram write
	localparam logic [1:0] TO_DRAM_NONE = 2'b11;

	// ==================================================
	// encodings
	// ==================================================

	// codes 2, 5 and 7 are not implemented and give zero
	typedef enum logic [2:0] {
		OP_ADD   = 3'd0,
		OP_SUB   = 3'd1,
		OP_L1    = 3'd3,
		OP_MAC   = 3'd4,
		OP_LOGIC = 3'd6
	} alu_opcode_e;

	// codes 6 and 7 select zero
	typedef enum logic [2:0] {
		SRC_CONST = 3'd0,
		SRC_REG   = 3'd1,
		SRC_SRAM0 = 3'd2,
		SRC_SRAM1 = 3'd3,
		SRC_TEMP0 = 3'd4,
		SRC_TEMP1 = 3'd5
	} src_sel_e;

	// one instruction as it arrives with op rdy
	typedef struct packed {
		alu_opcode_e opcode;
		shamt_t      shamt;
		src_sel_e    src_a;
		src_sel_e    src_b;
		src_sel_e    src_c;
		elem_t       const_a;
		elem_t       const_b;
		elem_t       const_c;
		reg_addr_t   reg_raddr;
		logic        to_reg;
		reg_addr_t   reg_waddr;
		logic        to_temp;
		// 3 means no dram write and any other code shifts the result by twice its value
		logic [1:0]  to_dram;
	} alu_inst_t;

endpackage

`default_nettype wire

// ==== rtl/operand_select.sv ====
// operand select: picks one four-lane operand from the constant, register, sram or temp sources
`default_nettype none
`timescale 1ns/1ns

module operand_select
	import alu_pkg::*;
(
	input  src_sel_e  i_sel,
	input  elem_t     i_const,
	input  elem_vec_t i_reg,
	input  data_vec_t i_sram0,
	input  data_vec_t i_sram1,
	input  elem_vec_t i_temp0,
	input  elem_vec_t i_temp1,
	output elem_vec_t o_opnd
);

	always_comb begin
		case (i_sel)
			SRC_CONST: begin
				// constant goes to every lane
				for (int i = 0; i < LANES; i++) begin
					o_opnd[i] = i_const;
				end
			end
			SRC_REG: begin
				o_opnd = i_reg;
			end
			SRC_SRAM0: begin
				// sram bytes are signed, extend to the working width
				for (int i = 0; i < LANES; i++) begin
					o_opnd[i] = elem_t'($signed(i_sram0[i]));
				end
			end
			SRC_SRAM1: begin
				for (int i = 0; i < LANES; i++) begin
					o_opnd[i] = elem_t'($signed(i_sram1[i]));
				end
			end
			SRC_TEMP0: begin
				// newest result
				o_opnd = i_temp0;
			end
			SRC_TEMP1: begin
				o_opnd = i_temp1;
			end
			default: begin
				o_opnd = '0;
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== rtl/vector_compute.sv ====
// vector compute: lane-wise add, sub, l1 distance, mac and logic group with right shift
`default_nettype none
`timescale 1ns/1ns

module vector_compute
	import alu_pkg::*;
(
	input  alu_opcode_e i_opcode,
	input  shamt_t      i_shamt,
	input  elem_vec_t   i_a,
	input  elem_vec_t   i_b,
	input  elem_vec_t   i_c,
	output elem_vec_t   o_result
);

	// ==================================================
	// per-lane datapath
	// ==================================================

	// every sum wraps at 16 bits, the shift is arithmetic and only
	// applies to the b/c term, a is added unshifted
	always_comb begin
		for (int l = 0; l < LANES; l++) begin : lane
			elem_t a;
			elem_t b;
			elem_t c;
			elem_t sum_bc;
			elem_t dif_bc;
			elem_t abs_bc;
			elem_t prod;
			elem_t res;

			a = i_a[l];
			b = i_b[l];
			c = i_c[l];
			sum_bc = b + c;
			dif_bc = b - c;
			abs_bc = dif_bc[15] ? -dif_bc : dif_bc;
			// signed product of the low bytes, fits in 16 bits
			prod = $signed(b[7:0]) * $signed(c[7:0]);

			case (i_opcode)
				OP_ADD:   res = a + (sum_bc >>> i_shamt);
				OP_SUB:   res = a + (dif_bc >>> i_shamt);
				OP_L1:    res = a + (abs_bc >>> i_shamt);
				OP_MAC:   res = a + (prod >>> i_shamt);
				OP_LOGIC: begin
					// shamt carries the sub-code here
					case (i_shamt)
						5'd0: res = (a == '0) ? b : c;
						5'd2: res = (b > c) ? b : c;
						5'd3: res = (b < c) ? b : c;
						default: res = '0;
					endcase
				end
				default:  res = '0;
			endcase

			o_result[l] = res;
		end
	end

endmodule

`default_nettype wire

// ==== rtl/issue_ctrl.sv ====
// issue control: op, sram and dram handshakes, write enables and the commit pulse
`default_nettype none
`timescale 1ns/1ns

module issue_ctrl
	import alu_pkg::*;
(
	input  logic       i_clk,
	input  logic       i_rst,
	input  logic       i_op_rdy,
	output logic       o_op_ack,
	input  src_sel_e   i_src_a,
	input  src_sel_e   i_src_b,
	input  src_sel_e   i_src_c,
	input  logic [1:0] i_to_dram,
	input  logic       i_to_reg,
	input  logic       i_to_temp,
	input  logic       i_sramrd0_rdy,
	output logic       o_sramrd0_ack,
	input  logic       i_sramrd1_rdy,
	output logic       o_sramrd1_ack,
	output logic       o_dramwd_rdy,
	input  logic       i_dramwd_ack,
	output logic       o_reg_we,
	output logic       o_temp_we,
	output logic       o_inst_commit
);

	logic need_rd0;
	logic need_rd1;
	logic to_dram;
	logic data_ready;

	// a stream is needed if any operand names it
	assign need_rd0 = (i_src_a == SRC_SRAM0) || (i_src_b == SRC_SRAM0) || (i_src_c == SRC_SRAM0);
	assign need_rd1 = (i_src_a == SRC_SRAM1) || (i_src_b == SRC_SRAM1) || (i_src_c == SRC_SRAM1);
	assign to_dram = i_to_dram != TO_DRAM_NONE;

	assign data_ready = i_op_rdy && (!need_rd0 || i_sramrd0_rdy) && (!need_rd1 || i_sramrd1_rdy);

	// with a dram write the op finishes on the dram ack
	assign o_dramwd_rdy = data_ready && to_dram;
	assign o_op_ack = to_dram ? (o_dramwd_rdy && i_dramwd_ack) : data_ready;

	assign o_sramrd0_ack = o_op_ack && need_rd0;
	assign o_sramrd1_ack = o_op_ack && need_rd1;
	assign o_reg_we = o_op_ack && i_to_reg;
	assign o_temp_we = o_op_ack && i_to_temp;
	assign o_inst_commit = o_op_ack;

	// ==================================================
	// protocol checks
	// ==================================================

	// a stream is never consumed unless its producer offers data
	a_sram_ack_has_rdy: assert property (@(posedge i_clk) disable iff (i_rst)
		(o_sramrd0_ack |-> i_sramrd0_rdy) and (o_sramrd1_ack |-> i_sramrd1_rdy));

	// once offered, dram data stays offered until taken
	a_dramwd_rdy_held: assert property (@(posedge i_clk) disable iff (i_rst)
		o_dramwd_rdy && !i_dramwd_ack |=> o_dramwd_rdy);

endmodule

`default_nettype wire

// ==== rtl/vector_alu.sv ====
// vector alu: operand selection, lane compute, dram narrowing and issue handshakes
`default_nettype none
`timescale 1ns/1ns

module vector_alu
	import alu_pkg::*;
(
	input  logic      i_clk,
	input  logic      i_rst,
	input  logic      i_op_rdy,
	output logic      o_op_ack,
	input  alu_inst_t i_inst,
	input  elem_vec_t i_reg_rdata,
	input  elem_vec_t i_temp0,
	input  elem_vec_t i_temp1,
	input  logic      i_sramrd0_rdy,
	output logic      o_sramrd0_ack,
	input  data_vec_t i_sramrd0,
	input  logic      i_sramrd1_rdy,
	output logic      o_sramrd1_ack,
	input  data_vec_t i_sramrd1,
	output logic      o_dramwd_rdy,
	input  logic      i_dramwd_ack,
	output data_vec_t o_dramwd,
	output logic      o_reg_we,
	output reg_addr_t o_reg_waddr,
	output logic      o_temp_we,
	output elem_vec_t o_result,
	output logic      o_inst_commit
);

	elem_vec_t opnd_a;
	elem_vec_t opnd_b;
	elem_vec_t opnd_c;
	logic [2:0] dram_shift;

	// ==================================================
	// operands and compute
	// ==================================================

	operand_select u_sel_a (
		.i_sel(i_inst.src_a), .i_const(i_inst.const_a), .i_reg(i_reg_rdata),
		.i_sram0(i_sramrd0), .i_sram1(i_sramrd1),
		.i_temp0(i_temp0), .i_temp1(i_temp1), .o_opnd(opnd_a)
	);

	operand_select u_sel_b (
		.i_sel(i_inst.src_b), .i_const(i_inst.const_b), .i_reg(i_reg_rdata),
		.i_sram0(i_sramrd0), .i_sram1(i_sramrd1),
		.i_temp0(i_temp0), .i_temp1(i_temp1), .o_opnd(opnd_b)
	);

	operand_select u_sel_c (
		.i_sel(i_inst.src_c), .i_const(i_inst.const_c), .i_reg(i_reg_rdata),
		.i_sram0(i_sramrd0), .i_sram1(i_sramrd1),
		.i_temp0(i_temp0), .i_temp1(i_temp1), .o_opnd(opnd_c)
	);

	vector_compute u_compute (
		.i_opcode(i_inst.opcode), .i_shamt(i_inst.shamt),
		.i_a(opnd_a), .i_b(opnd_b), .i_c(opnd_c), .o_result(o_result)
	);

	// dram lanes keep the low byte after a shift of 0, 2, 4 or 6
	assign dram_shift = {i_inst.to_dram, 1'b0};

	always_comb begin
		for (int i = 0; i < LANES; i++) begin
			o_dramwd[i] = data_t'(o_result[i] >> dram_shift);
		end
	end

	assign o_reg_waddr = i_inst.reg_waddr;

	// ==================================================
	// handshakes
	// ==================================================

	issue_ctrl u_issue (
		.i_clk(i_clk), .i_rst(i_rst),
		.i_op_rdy(i_op_rdy), .o_op_ack(o_op_ack),
		.i_src_a(i_inst.src_a), .i_src_b(i_inst.src_b), .i_src_c(i_inst.src_c),
		.i_to_dram(i_inst.to_dram), .i_to_reg(i_inst.to_reg), .i_to_temp(i_inst.to_temp),
		.i_sramrd0_rdy(i_sramrd0_rdy), .o_sramrd0_ack(o_sramrd0_ack),
		.i_sramrd1_rdy(i_sramrd1_rdy), .o_sramrd1_ack(o_sramrd1_ack),
		.o_dramwd_rdy(o_dramwd_rdy), .i_dramwd_ack(i_dramwd_ack),
		.o_reg_we(o_reg_we), .o_temp_we(o_temp_we), .o_inst_commit(o_inst_commit)
	);

endmodule

`default_nettype wire

// ==== rtl/vector_reg_file.sv ====
// vector register file: one combinational read port, one synchronous write port
`default_nettype none
`timescale 1ns/1ns

module vector_reg_file
	import alu_pkg::*;
#(
	parameter int NREG = 16
) (
	input  logic      i_clk,
	input  logic      i_rst,
	input  reg_addr_t i_raddr,
	output elem_vec_t o_rdata,
	input  logic      i_we,
	input  reg_addr_t i_waddr,
	input  elem_vec_t i_wdata
);

	elem_vec_t regs [NREG];

	// addresses past the last register read as zero
	assign o_rdata = (i_raddr < NREG) ? regs[i_raddr] : '0;

	// whole file clears so early reads see zero
	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			for (int i = 0; i < NREG; i++) begin
				regs[i] <= '0;
			end
		end else if (i_we) begin
			regs[i_waddr] <= i_wdata;
		end
	end

	// the instruction must not name a register this file lacks
	a_waddr_in_range: assert property (@(posedge i_clk) disable iff (i_rst)
		i_we |-> i_waddr < NREG);

endmodule

`default_nettype wire

// ==== rtl/temp_buffer.sv ====
// temp buffer: two-entry delay line of the most recent alu results
`default_nettype none
`timescale 1ns/1ns

module temp_buffer
	import alu_pkg::*;
(
	input  logic      i_clk,
	input  logic      i_rst,
	input  logic      i_we,
	input  elem_vec_t i_wdata,
	output elem_vec_t o_temp0,
	output elem_vec_t o_temp1
);

	elem_vec_t slot0;
	elem_vec_t slot1;

	// a write shifts the line, slot 0 always holds the newest result
	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			slot0 <= '0;
			slot1 <= '0;
		end else if (i_we) begin
			slot0 <= i_wdata;
			slot1 <= slot0;
		end
	end

	assign o_temp0 = slot0;
	assign o_temp1 = slot1;

endmodule

`default_nettype wire

// ==== rtl/alu_stage_top.sv ====
// alu stage top: vector alu with its register file and temp buffer
`default_nettype none
`timescale 1ns/1ns

module alu_stage_top
	import alu_pkg::*;
#(
	parameter int NREG = 16
) (
	input  logic      i_clk,
	input  logic      i_rst,
	input  logic      i_op_rdy,
	output logic      o_op_ack,
	input  alu_inst_t i_inst,
	input  logic      i_sramrd0_rdy,
	output logic      o_sramrd0_ack,
	input  data_vec_t i_sramrd0,
	input  logic      i_sramrd1_rdy,
	output logic      o_sramrd1_ack,
	input  data_vec_t i_sramrd1,
	output logic      o_dramwd_rdy,
	input  logic      i_dramwd_ack,
	output data_vec_t o_dramwd,
	output logic      o_inst_commit
);

	elem_vec_t reg_rdata;
	elem_vec_t temp0;
	elem_vec_t temp1;
	elem_vec_t result;
	logic      reg_we;
	reg_addr_t reg_waddr;
	logic      temp_we;

	vector_alu u_alu (
		.i_clk(i_clk), .i_rst(i_rst),
		.i_op_rdy(i_op_rdy), .o_op_ack(o_op_ack), .i_inst(i_inst),
		.i_reg_rdata(reg_rdata), .i_temp0(temp0), .i_temp1(temp1),
		.i_sramrd0_rdy(i_sramrd0_rdy), .o_sramrd0_ack(o_sramrd0_ack), .i_sramrd0(i_sramrd0),
		.i_sramrd1_rdy(i_sramrd1_rdy), .o_sramrd1_ack(o_sramrd1_ack), .i_sramrd1(i_sramrd1),
		.o_dramwd_rdy(o_dramwd_rdy), .i_dramwd_ack(i_dramwd_ack), .o_dramwd(o_dramwd),
		.o_reg_we(reg_we), .o_reg_waddr(reg_waddr), .o_temp_we(temp_we),
		.o_result(result), .o_inst_commit(o_inst_commit)
	);

	// read address comes straight from the instruction
	vector_reg_file #(
		.NREG(NREG)
	) u_reg_file (
		.i_clk(i_clk), .i_rst(i_rst),
		.i_raddr(i_inst.reg_raddr), .o_rdata(reg_rdata),
		.i_we(reg_we), .i_waddr(reg_waddr), .i_wdata(result)
	);

	temp_buffer u_temp (
		.i_clk(i_clk), .i_rst(i_rst),
		.i_we(temp_we), .i_wdata(result),
		.o_temp0(temp0), .o_temp1(temp1)
	);

endmodule

`default_nettype wire

// ==== sim/alu_stage_tb.sv ====
// alu stage testbench: directed tests of the vector alu stage against a lane model
`default_nettype none
`timescale 1ns/1ns

module alu_stage_tb
	import alu_pkg::*;
;

	// the longest run is well under 300 cycles
	localparam int MAX_CYCLES = 2000;
	localparam int SEED = 6652;

	logic      clk;
	logic      rst;
	logic      op_rdy;
	alu_inst_t inst;
	logic      sramrd0_rdy;
	data_vec_t sramrd0;
	logic      sramrd1_rdy;
	data_vec_t sramrd1;
	logic      dramwd_ack;
	logic      o_op_ack;
	logic      o_sramrd0_ack;
	logic      o_sramrd1_ack;
	logic      o_dramwd_rdy;
	data_vec_t o_dramwd;
	logic      o_inst_commit;

	// model state that follows every commit
	elem_vec_t m_regs [16];
	elem_vec_t m_temp0;
	elem_vec_t m_temp1;
	int        commits;
	int        cycles;
	int        checks;
	int        errors;

	alu_stage_top #(
		.NREG(16)
	) uut (
		.i_clk(clk), .i_rst(rst), .i_op_rdy(op_rdy), .o_op_ack(o_op_ack), .i_inst(inst),
		.i_sramrd0_rdy(sramrd0_rdy), .o_sramrd0_ack(o_sramrd0_ack), .i_sramrd0(sramrd0),
		.i_sramrd1_rdy(sramrd1_rdy), .o_sramrd1_ack(o_sramrd1_ack), .i_sramrd1(sramrd1),
		.o_dramwd_rdy(o_dramwd_rdy), .i_dramwd_ack(dramwd_ack), .o_dramwd(o_dramwd),
		.o_inst_commit(o_inst_commit)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// ==================================================
	// reference model
	// ==================================================

	function automatic elem_t lane_model(alu_opcode_e op, shamt_t sh, elem_t a, elem_t b,
			elem_t c);
		elem_t d;
		int t;
		case (op)
			OP_ADD: begin
				d = elem_t'(int'(b) + int'(c));
				t = int'(d) >>> sh;
			end
			OP_SUB: begin
				d = elem_t'(int'(b) - int'(c));
				t = int'(d) >>> sh;
			end
			OP_L1: begin
				d = elem_t'(int'(b) - int'(c));
				// absolute value wraps too, so -32768 stays negative
				d = (d < 0) ? elem_t'(-int'(d)) : d;
				t = int'(d) >>> sh;
			end
			OP_MAC: t = (int'($signed(b[7:0])) * int'($signed(c[7:0]))) >>> sh;
			OP_LOGIC: begin
				if (sh == 5'd0) return (a == 0) ? b : c;
				if (sh == 5'd2) return (b > c) ? b : c;
				if (sh == 5'd3) return (b < c) ? b : c;
				return '0;
			end
			default: return '0;
		endcase
		return elem_t'(int'(a) + t);
	endfunction

	function automatic elem_t operand_model(src_sel_e sel, elem_t k, int lane,
			reg_addr_t raddr, data_vec_t s0, data_vec_t s1);
		case (sel)
			SRC_CONST: return k;
			SRC_REG:   return m_regs[raddr][lane];
			SRC_SRAM0: return {{8{s0[lane][7]}}, s0[lane]};
			SRC_SRAM1: return {{8{s1[lane][7]}}, s1[lane]};
			SRC_TEMP0: return m_temp0[lane];
			SRC_TEMP1: return m_temp1[lane];
			default:   return '0;
		endcase
	endfunction

	function automatic elem_vec_t model_result(alu_inst_t x, data_vec_t s0, data_vec_t s1);
		elem_vec_t r;
		for (int l = 0; l < LANES; l++) begin
			r[l] = lane_model(x.opcode, x.shamt,
				operand_model(x.src_a, x.const_a, l, x.reg_raddr, s0, s1),
				operand_model(x.src_b, x.const_b, l, x.reg_raddr, s0, s1),
				operand_model(x.src_c, x.const_c, l, x.reg_raddr, s0, s1));
		end
		return r;
	endfunction

	// dram lane is the low byte after a shift of twice the code
	function automatic data_vec_t narrow(elem_vec_t r, logic [1:0] td);
		data_vec_t d;
		logic [15:0] tmp;
		for (int l = 0; l < LANES; l++) begin
			tmp = r[l];
			tmp = tmp >> (2 * td);
			d[l] = tmp[7:0];
		end
		return d;
	endfunction

	function automatic logic uses_src(alu_inst_t x, src_sel_e s);
		return (x.src_a == s) || (x.src_b == s) || (x.src_c == s);
	endfunction

	always @(posedge clk) begin
		elem_vec_t r;
		if (rst) begin
			for (int i = 0; i < 16; i++) begin
				m_regs[i] = '0;
			end
			m_temp0 = '0;
			m_temp1 = '0;
		end else if (o_inst_commit) begin
			r = model_result(inst, sramrd0, sramrd1);
			if (inst.to_reg) m_regs[inst.reg_waddr] = r;
			if (inst.to_temp) begin
				m_temp1 = m_temp0;
				m_temp0 = r;
			end
			commits++;
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= MAX_CYCLES) begin
			$display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
			$display("Simulation failed");
			$finish;
		end
	end

	// ==================================================
	// compare tasks and drivers
	// ==================================================

	task automatic compare_data_vec(string name, data_vec_t got, data_vec_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Mismatch at %0t: %s expected %h got %h", $time, name, exp, got);
		end
	endtask

	task automatic compare_elem(string name, elem_t got, elem_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Mismatch at %0t: %s expected %h got %h", $time, name, exp, got);
		end
	endtask

	task automatic compare_bit(string name, logic got, logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Mismatch at %0t: %s expected %b got %b", $time, name, exp, got);
		end
	endtask

	function automatic alu_inst_t make_inst(alu_opcode_e op, shamt_t sh, src_sel_e sa,
			src_sel_e sb, src_sel_e sc, elem_t ka, elem_t kb, elem_t kc);
		alu_inst_t x;
		x = '0;
		x.opcode = op;
		x.shamt = sh;
		x.src_a = sa;
		x.src_b = sb;
		x.src_c = sc;
		x.const_a = ka;
		x.const_b = kb;
		x.const_c = kc;
		return x;
	endfunction

	function automatic data_vec_t rand_data_vec();
		data_vec_t d;
		for (int l = 0; l < LANES; l++) begin
			d[l] = data_t'($urandom());
		end
		return d;
	endfunction

	// leaves the drive at the falling edge
	task automatic drive(alu_inst_t x, data_vec_t s0, data_vec_t s1, logic r0, logic r1,
			logic dack);
		@(negedge clk);
		inst = x;
		sramrd0 = s0;
		sramrd1 = s1;
		sramrd0_rdy = r0;
		sramrd1_rdy = r1;
		dramwd_ack = dack;
		op_rdy = 1'b1;
	endtask

	task automatic release_inputs();
		op_rdy = 1'b0;
		sramrd0_rdy = 1'b0;
		sramrd1_rdy = 1'b0;
		dramwd_ack = 1'b0;
	endtask

	// issues one instruction with every producer ready and checks it at the ack
	task automatic run_inst(alu_inst_t x, data_vec_t s0, data_vec_t s1);
		elem_vec_t exp_res;
		exp_res = model_result(x, s0, s1);
		drive(x, s0, s1, 1'b1, 1'b1, 1'b1);
		#1;
		while (!o_op_ack) begin
			@(negedge clk);
			#1;
		end
		compare_bit("o_sramrd0_ack", o_sramrd0_ack, uses_src(x, SRC_SRAM0));
		compare_bit("o_sramrd1_ack", o_sramrd1_ack, uses_src(x, SRC_SRAM1));
		compare_bit("o_dramwd_rdy", o_dramwd_rdy, x.to_dram != TO_DRAM_NONE);
		compare_bit("o_inst_commit", o_inst_commit, 1'b1);
		if (x.to_dram != TO_DRAM_NONE) begin
			compare_data_vec("o_dramwd", o_dramwd, narrow(exp_res, x.to_dram));
		end
		for (int l = 0; l < LANES; l++) begin
			compare_elem($sformatf("result[%0d]", l), uut.result[l], exp_res[l]);
		end
		@(posedge clk);
		@(negedge clk);
		release_inputs();
	endtask

	task automatic report_test(string name, int errs_before);
		$display("test %s finished with %0d errors", name, errors - errs_before);
	endtask

	// ==================================================
	// tests
	// ==================================================

	task automatic test_add_sub();
		alu_inst_t x;
		int e0;
		e0 = errors;
		for (int td = 0; td < 3; td++) begin
			for (int op = 0; op < 2; op++) begin
				x = make_inst(op == 0 ? OP_ADD : OP_SUB, shamt_t'($urandom_range(3)),
					SRC_CONST, SRC_SRAM0, SRC_SRAM1, elem_t'($urandom()), '0, '0);
				x.to_dram = td[1:0];
				run_inst(x, rand_data_vec(), rand_data_vec());
			end
		end
		report_test("add_sub", e0);
	endtask

	task automatic test_l1_mac();
		alu_inst_t x;
		int e0;
		e0 = errors;
		for (int i = 0; i < 6; i++) begin
			x = make_inst(i[0] ? OP_MAC : OP_L1, shamt_t'($urandom_range(4)),
				SRC_SRAM0, SRC_SRAM1, SRC_CONST, '0, '0, elem_t'($urandom()));
			run_inst(x, rand_data_vec(), rand_data_vec());
		end
		report_test("l1_mac", e0);
	endtask

	task automatic test_logic();
		alu_inst_t x;
		int e0;
		e0 = errors;
		x = make_inst(OP_LOGIC, 5'd0, SRC_CONST, SRC_SRAM0, SRC_SRAM1, '0, '0, '0);
		run_inst(x, rand_data_vec(), rand_data_vec());
		x.const_a = 16'sd5;
		run_inst(x, rand_data_vec(), rand_data_vec());
		x.shamt = 5'd2;
		run_inst(x, rand_data_vec(), rand_data_vec());
		x.shamt = 5'd3;
		run_inst(x, rand_data_vec(), rand_data_vec());
		x.shamt = 5'd7;
		run_inst(x, rand_data_vec(), rand_data_vec());
		// opcodes 2 and 5 have no operation behind them
		x = make_inst(alu_opcode_e'(3'd2), 5'd0, SRC_CONST, SRC_SRAM0, SRC_SRAM1,
			16'sd9, '0, '0);
		run_inst(x, rand_data_vec(), rand_data_vec());
		x.opcode = alu_opcode_e'(3'd5);
		run_inst(x, rand_data_vec(), rand_data_vec());
		report_test("logic", e0);
	endtask

	task automatic test_chain();
		alu_inst_t x;
		int e0;
		e0 = errors;
		// register 9 and both temp slots are still zero here
		x = make_inst(OP_ADD, 5'd0, SRC_REG, SRC_TEMP0, SRC_TEMP1, '0, '0, '0);
		x.reg_raddr = 4'd9;
		run_inst(x, '0, '0);
		x = make_inst(OP_ADD, 5'd0, SRC_CONST, SRC_SRAM0, SRC_CONST,
			elem_t'($urandom_range(200)), '0, '0);
		x.to_reg = 1'b1;
		x.reg_waddr = 4'd9;
		x.to_temp = 1'b1;
		x.to_dram = TO_DRAM_NONE;
		run_inst(x, rand_data_vec(), '0);
		x = make_inst(OP_SUB, 5'd0, SRC_CONST, SRC_SRAM1, SRC_SRAM0,
			elem_t'($urandom_range(200)), '0, '0);
		x.to_temp = 1'b1;
		x.to_dram = 2'd1;
		run_inst(x, rand_data_vec(), rand_data_vec());
		x = make_inst(OP_ADD, 5'd1, SRC_REG, SRC_TEMP0, SRC_TEMP1, '0, '0, '0);
		x.reg_raddr = 4'd9;
		run_inst(x, '0, '0);
		x = make_inst(OP_LOGIC, 5'd2, SRC_CONST, SRC_TEMP0, SRC_TEMP1, '0, '0, '0);
		run_inst(x, '0, '0);
		report_test("chain", e0);
	endtask

	task automatic test_backpressure();
		alu_inst_t x;
		data_vec_t s0;
		elem_vec_t exp_res;
		int e0;
		int c0;
		e0 = errors;
		s0 = rand_data_vec();
		x = make_inst(OP_ADD, 5'd0, SRC_CONST, SRC_SRAM0, SRC_CONST, 16'sd3, '0, 16'sd1);
		exp_res = model_result(x, s0, '0);
		c0 = commits;
		// stream 0 not ready yet
		drive(x, s0, '0, 1'b0, 1'b1, 1'b1);
		repeat (4) begin
			#1;
			compare_bit("o_op_ack", o_op_ack, 1'b0);
			compare_bit("o_sramrd0_ack", o_sramrd0_ack, 1'b0);
			compare_bit("o_inst_commit", o_inst_commit, 1'b0);
			compare_bit("o_dramwd_rdy", o_dramwd_rdy, 1'b0);
			@(negedge clk);
		end
		sramrd0_rdy = 1'b1;
		dramwd_ack = 1'b0;
		repeat (5) begin
			#1;
			compare_bit("o_dramwd_rdy", o_dramwd_rdy, 1'b1);
			compare_bit("o_op_ack", o_op_ack, 1'b0);
			compare_bit("o_sramrd0_ack", o_sramrd0_ack, 1'b0);
			compare_bit("o_inst_commit", o_inst_commit, 1'b0);
			@(negedge clk);
		end
		if (commits != c0) begin
			errors++;
			$display("instruction committed while its handshake was held off");
		end
		dramwd_ack = 1'b1;
		#1;
		compare_bit("o_op_ack", o_op_ack, 1'b1);
		compare_bit("o_sramrd0_ack", o_sramrd0_ack, 1'b1);
		compare_data_vec("o_dramwd", o_dramwd, narrow(exp_res, 2'd0));
		@(posedge clk);
		@(negedge clk);
		release_inputs();
		repeat (2) @(negedge clk);
		if (commits != c0 + 1) begin
			errors++;
			$display("expected one commit after release, saw %0d", commits - c0);
		end
		// register-only write needs no dram ack
		x = make_inst(OP_ADD, 5'd0, SRC_CONST, SRC_CONST, SRC_CONST, 16'sd40, 16'sd2, '0);
		x.to_reg = 1'b1;
		x.reg_waddr = 4'd7;
		x.to_dram = TO_DRAM_NONE;
		drive(x, '0, '0, 1'b0, 1'b0, 1'b0);
		#1;
		compare_bit("o_op_ack", o_op_ack, 1'b1);
		compare_bit("o_dramwd_rdy", o_dramwd_rdy, 1'b0);
		compare_bit("o_inst_commit", o_inst_commit, 1'b1);
		@(posedge clk);
		@(negedge clk);
		release_inputs();
		x = make_inst(OP_ADD, 5'd0, SRC_REG, SRC_CONST, SRC_CONST, '0, '0, '0);
		x.reg_raddr = 4'd7;
		run_inst(x, '0, '0);
		report_test("backpressure", e0);
	endtask

	initial begin
		rst = 1'b1;
		op_rdy = 1'b0;
		inst = '0;
		sramrd0_rdy = 1'b0;
		sramrd0 = '0;
		sramrd1_rdy = 1'b0;
		sramrd1 = '0;
		dramwd_ack = 1'b0;
		commits = 0;
		cycles = 0;
		checks = 0;
		errors = 0;
		void'($urandom(SEED));
		repeat (16) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		test_chain();
		test_add_sub();
		test_l1_mac();
		test_logic();
		test_backpressure();

		$display("checks %0d, errors %0d, commits %0d", checks, errors, commits);
		if (errors == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== vlog.f ====
rtl/alu_pkg.sv
rtl/operand_select.sv
rtl/vector_compute.sv
rtl/issue_ctrl.sv
rtl/vector_alu.sv
rtl/vector_reg_file.sv
rtl/temp_buffer.sv
rtl/alu_stage_top.sv
sim/alu_stage_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the alu stage testbench with Verilator
verilator --binary --timing --assert -f vlog.f --top-module alu_stage_tb \
	-o alu_stage_sim > build.log 2>&1 || { cat build.log; echo "build error"; exit 1; }
./obj_dir/alu_stage_sim > sim.log 2>&1 || echo "run aborted before the end" >> sim.log
cat sim.log
grep -q "Simulation failed" sim.log && exit 1
grep -q "run aborted" sim.log && exit 1 || exit 0
